// File: project.f
rtl/fetch_pkg.sv
rtl/fetch_stream_if.sv
rtl/pc_target_mux.sv
rtl/fetch_controller.sv
rtl/prefetch_fifo.sv
rtl/if_id_register.sv
rtl/if_stage.sv
tb/if_stage_assert.sv
tb/tb_if_stage.sv

// File: rtl/fetch_controller.sv
/*
 * Fetch controller
 * PC register, single outstanding memory request and response capture
 */

`timescale 1ns/100ps

module fetch_controller (
        input  logic                    clk,
        input  logic                    rst_n_i,
        input  logic                    req_i,
        input  logic                    pc_set_i,
        input  fetch_pkg::pc_mux_e      pc_mux_i,
        input  fetch_pkg::addr_t        boot_addr_i,
        input  fetch_pkg::addr_t        jump_target_i,
        input  fetch_pkg::addr_t        mepc_i,
        input  fetch_pkg::tvec_base_t   trap_base_i,
        input  logic                    trap_vectored_i,
        input  fetch_pkg::exc_cause_t   exc_cause_i,
        output logic                    instr_req_o,
        output fetch_pkg::addr_t        instr_addr_o,
        input  logic                    instr_gnt_i,
        input  logic                    instr_rvalid_i,
        input  fetch_pkg::instr_t       instr_rdata_i,
        input  logic                    instr_err_i,
        output logic                    busy_o,
        fetch_stream_if.producer        fill
);
        import fetch_pkg::*;

        addr_t  target;
        addr_t  pc_q;
        logic   pc_valid_q;
        logic   outstanding_q;
        logic   discard_q;
        logic   hold_q;
        addr_t  hold_addr_q;
        addr_t  rsp_addr_q;
        logic   gnt_fire;
        logic   pc_match;

        pc_target_mux u_pc_target_mux (
                .pc_mux_i        (pc_mux_i),
                .boot_addr_i     (boot_addr_i),
                .jump_target_i   (jump_target_i),
                .trap_base_i     (trap_base_i),
                .trap_vectored_i (trap_vectored_i),
                .exc_cause_i     (exc_cause_i),
                .mepc_i          (mepc_i),
                .target_o        (target)
        );

        // ------------------------------------------------------------------------
        // Request side
        // ------------------------------------------------------------------------

        // An ungranted request is held with its address until the grant
        assign instr_req_o  = hold_q ||
                              (req_i && pc_valid_q && fill.ready && !outstanding_q && !pc_set_i);
        assign instr_addr_o = hold_q ? hold_addr_q : pc_q;
        assign gnt_fire     = instr_req_o && instr_gnt_i;
        // A held request issued before a redirect no longer matches the PC
        assign pc_match     = (instr_addr_o == pc_q);

        always_ff @(posedge clk or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        pc_q          <= '0;
                        pc_valid_q    <= 1'b0;
                        outstanding_q <= 1'b0;
                        discard_q     <= 1'b0;
                        hold_q        <= 1'b0;
                end else begin
                        if (pc_set_i) begin
                                pc_q       <= target;
                                pc_valid_q <= 1'b1;
                        end else if (gnt_fire && pc_match) begin
                                pc_q <= pc_q + 32'd4;
                        end
                        hold_q <= instr_req_o && !instr_gnt_i;
                        if (gnt_fire) begin
                                outstanding_q <= 1'b1;
                                discard_q     <= pc_set_i || !pc_match;
                        end else if (instr_rvalid_i) begin
                                outstanding_q <= 1'b0;
                                discard_q     <= 1'b0;
                        end else if (pc_set_i && outstanding_q) begin
                                discard_q <= 1'b1;
                        end
                end
        end

        always_ff @(posedge clk) begin
                hold_addr_q <= instr_addr_o;
                if (gnt_fire) begin
                        rsp_addr_q <= instr_addr_o;
                end
        end

        // ------------------------------------------------------------------------
        // Response side
        // ------------------------------------------------------------------------

        assign fill.valid = instr_rvalid_i && outstanding_q && !discard_q;
        assign fill.entry = '{addr: rsp_addr_q, rdata: instr_rdata_i, err: instr_err_i};
        assign fill.flush = pc_set_i;
        assign busy_o     = outstanding_q;

endmodule

// File: rtl/fetch_pkg.sv
/*
 * Shared types of the instruction fetch stage
 * Addresses, instruction words, redirect kinds and queue entries
 */

package fetch_pkg;

        typedef logic [31:0] addr_t;
        typedef logic [31:0] instr_t;

        // Redirect kind selected together with pc_set_i
        typedef enum logic [1:0] {
                PC_BOOT      = 2'b00,
                PC_JUMP      = 2'b01,
                PC_EXCEPTION = 2'b10,
                PC_MRET      = 2'b11
        } pc_mux_e;

        typedef logic [4:0]  exc_cause_t;
        typedef logic [23:0] tvec_base_t;

        // One fetched word with its address and bus error
        typedef struct packed {
                addr_t  addr;
                instr_t rdata;
                logic   err;
        } fetch_entry_t;

        parameter int FIFO_DEPTH_DEFAULT = 4;

endpackage

// File: rtl/fetch_stream_if.sv
/*
 * Entry stream between fetch blocks
 * valid/ready transfer plus a flush toward the consumer
 */

`timescale 1ns/100ps

interface fetch_stream_if #(
        parameter type entry_t = fetch_pkg::fetch_entry_t
) ();
        logic   valid;
        logic   ready;
        logic   flush;
        entry_t entry;

        modport producer (
                output valid, entry, flush,
                input  ready
        );

        modport consumer (
                input  valid, entry, flush,
                output ready
        );

endinterface

// File: rtl/if_id_register.sv
/*
 * IF/ID pipeline register
 * Decode-side copy of one fetched entry with stall, halt and clear
 */

`timescale 1ns/100ps

module if_id_register (
        input  logic                    clk,
        input  logic                    rst_n_i,
        input  logic                    id_ready_i,
        input  logic                    halt_if_i,
        input  logic                    clear_instr_valid_i,
        input  logic                    pc_set_i,
        fetch_stream_if.consumer        issue,
        output logic                    instr_valid_id_o,
        output fetch_pkg::instr_t       instr_rdata_id_o,
        output fetch_pkg::addr_t        pc_id_o,
        output logic                    is_fetch_failed_o,
        output logic                    perf_imiss_o
);
        import fetch_pkg::*;

        logic   want_pop;
        logic   pop;
        logic   active_q;
        instr_t rdata_q;
        addr_t  pc_q;
        logic   err_q;

        // Room when empty or when decode takes the current entry
        assign want_pop    = (!instr_valid_id_o || id_ready_i) && !halt_if_i;
        assign issue.ready = want_pop && !clear_instr_valid_i;
        assign pop         = issue.valid && issue.ready;

        always_ff @(posedge clk or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        instr_valid_id_o <= 1'b0;
                        active_q         <= 1'b0;
                end else begin
                        if (pc_set_i) begin
                                active_q <= 1'b1;
                        end
                        if (pc_set_i || clear_instr_valid_i) begin
                                instr_valid_id_o <= 1'b0;
                        end else if (pop) begin
                                instr_valid_id_o <= 1'b1;
                        end else if (id_ready_i) begin
                                instr_valid_id_o <= 1'b0;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (pop) begin
                        rdata_q <= issue.entry.rdata;
                        pc_q    <= issue.entry.addr;
                        err_q   <= issue.entry.err;
                end
        end

        assign instr_rdata_id_o  = rdata_q;
        assign pc_id_o           = pc_q;
        assign is_fetch_failed_o = err_q;
        // Miss counted only once fetching has been started by a redirect
        assign perf_imiss_o      = active_q && want_pop && !issue.valid;

endmodule

// File: rtl/if_stage.sv
/*
 * Instruction fetch stage top level
 * Fetch controller, prefetch queue and IF/ID register
 */

`timescale 1ns/100ps

module if_stage #(
        parameter int FIFO_DEPTH = fetch_pkg::FIFO_DEPTH_DEFAULT
) (
        input  logic                    clk,
        input  logic                    rst_n_i,
        input  logic                    req_i,
        input  logic                    pc_set_i,
        input  fetch_pkg::pc_mux_e      pc_mux_i,
        input  fetch_pkg::addr_t        boot_addr_i,
        input  fetch_pkg::addr_t        jump_target_i,
        input  fetch_pkg::addr_t        mepc_i,
        input  fetch_pkg::tvec_base_t   trap_base_i,
        input  logic                    trap_vectored_i,
        input  fetch_pkg::exc_cause_t   exc_cause_i,
        output logic                    instr_req_o,
        output fetch_pkg::addr_t        instr_addr_o,
        input  logic                    instr_gnt_i,
        input  logic                    instr_rvalid_i,
        input  fetch_pkg::instr_t       instr_rdata_i,
        input  logic                    instr_err_i,
        output logic                    if_busy_o,
        input  logic                    id_ready_i,
        input  logic                    halt_if_i,
        input  logic                    clear_instr_valid_i,
        output logic                    instr_valid_id_o,
        output fetch_pkg::instr_t       instr_rdata_id_o,
        output fetch_pkg::addr_t        pc_id_o,
        output logic                    is_fetch_failed_o,
        output logic                    perf_imiss_o
);
        import fetch_pkg::*;

        fetch_stream_if #(.entry_t(fetch_entry_t)) fill_bus ();
        fetch_stream_if #(.entry_t(fetch_entry_t)) issue_bus ();

        fetch_controller u_fetch_controller (
                .clk             (clk),
                .rst_n_i         (rst_n_i),
                .req_i           (req_i),
                .pc_set_i        (pc_set_i),
                .pc_mux_i        (pc_mux_i),
                .boot_addr_i     (boot_addr_i),
                .jump_target_i   (jump_target_i),
                .mepc_i          (mepc_i),
                .trap_base_i     (trap_base_i),
                .trap_vectored_i (trap_vectored_i),
                .exc_cause_i     (exc_cause_i),
                .instr_req_o     (instr_req_o),
                .instr_addr_o    (instr_addr_o),
                .instr_gnt_i     (instr_gnt_i),
                .instr_rvalid_i  (instr_rvalid_i),
                .instr_rdata_i   (instr_rdata_i),
                .instr_err_i     (instr_err_i),
                .busy_o          (if_busy_o),
                .fill            (fill_bus.producer)
        );

        prefetch_fifo #(
                .FIFO_DEPTH (FIFO_DEPTH),
                .entry_t    (fetch_entry_t)
        ) u_prefetch_fifo (
                .clk     (clk),
                .rst_n_i (rst_n_i),
                .fill    (fill_bus.consumer),
                .issue   (issue_bus.producer)
        );

        if_id_register u_if_id_register (
                .clk                 (clk),
                .rst_n_i             (rst_n_i),
                .id_ready_i          (id_ready_i),
                .halt_if_i           (halt_if_i),
                .clear_instr_valid_i (clear_instr_valid_i),
                .pc_set_i            (pc_set_i),
                .issue               (issue_bus.consumer),
                .instr_valid_id_o    (instr_valid_id_o),
                .instr_rdata_id_o    (instr_rdata_id_o),
                .pc_id_o             (pc_id_o),
                .is_fetch_failed_o   (is_fetch_failed_o),
                .perf_imiss_o        (perf_imiss_o)
        );

endmodule

// File: rtl/pc_target_mux.sv
/*
 * Redirect target selection
 * Boot, jump, trap vector and mret targets, all word aligned
 */

`timescale 1ns/100ps

module pc_target_mux (
        input  fetch_pkg::pc_mux_e      pc_mux_i,
        input  fetch_pkg::addr_t        boot_addr_i,
        input  fetch_pkg::addr_t        jump_target_i,
        input  fetch_pkg::tvec_base_t   trap_base_i,
        input  logic                    trap_vectored_i,
        input  fetch_pkg::exc_cause_t   exc_cause_i,
        input  fetch_pkg::addr_t        mepc_i,
        output fetch_pkg::addr_t        target_o
);
        import fetch_pkg::*;

        addr_t  vec_offset;
        addr_t  trap_target;

        // Vectored mode adds cause * 4 to the 256-byte aligned base
        assign vec_offset  = trap_vectored_i ? {25'b0, exc_cause_i, 2'b00} : '0;
        assign trap_target = {trap_base_i, 8'h00} + vec_offset;

        always_comb begin
                case (pc_mux_i)
                        PC_BOOT:      target_o = {boot_addr_i[31:2], 2'b00};
                        PC_JUMP:      target_o = {jump_target_i[31:2], 2'b00};
                        PC_EXCEPTION: target_o = trap_target;
                        PC_MRET:      target_o = {mepc_i[31:2], 2'b00};
                        default:      target_o = {boot_addr_i[31:2], 2'b00};
                endcase
        end

endmodule

// File: rtl/prefetch_fifo.sv
/*
 * Prefetch queue
 * Circular buffer of fetched entries with flush
 */

`timescale 1ns/100ps

module prefetch_fifo #(
        parameter int  FIFO_DEPTH = fetch_pkg::FIFO_DEPTH_DEFAULT,
        parameter type entry_t    = fetch_pkg::fetch_entry_t
) (
        input  logic                    clk,
        input  logic                    rst_n_i,
        fetch_stream_if.consumer        fill,
        fetch_stream_if.producer        issue
);
        localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
        localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

        entry_t             mem_q [FIFO_DEPTH];
        logic [PTR_W-1:0]   wr_ptr_q;
        logic [PTR_W-1:0]   rd_ptr_q;
        logic [CNT_W-1:0]   count_q;
        logic               push;
        logic               pop;

        assign push = fill.valid && fill.ready;
        assign pop  = issue.valid && issue.ready;

        // Pointers wrap explicitly so any depth works
        always_ff @(posedge clk or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        wr_ptr_q <= '0;
                        rd_ptr_q <= '0;
                        count_q  <= '0;
                end else if (fill.flush) begin
                        wr_ptr_q <= '0;
                        rd_ptr_q <= '0;
                        count_q  <= '0;
                end else begin
                        if (push) begin
                                wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
                        end
                        if (pop) begin
                                rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
                        end
                        if (push && !pop) begin
                                count_q <= count_q + 1'b1;
                        end else if (pop && !push) begin
                                count_q <= count_q - 1'b1;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (push && !fill.flush) begin
                        mem_q[wr_ptr_q] <= fill.entry;
                end
        end

        assign fill.ready  = (count_q < CNT_W'(FIFO_DEPTH));
        assign issue.valid = (count_q != '0);
        assign issue.entry = mem_q[rd_ptr_q];
        assign issue.flush = 1'b0;

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the fetch stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_if_stage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_if_stage)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1

// File: tb/if_stage_assert.sv
/*
 * Bound checks on the fetch stage top level
 * Memory request stability, idle outputs after reset, response pairing
 */

`timescale 1ns/100ps

module if_stage_assert (
        input  logic                    clk,
        input  logic                    rst_n_i,
        input  logic                    instr_req_o,
        input  fetch_pkg::addr_t        instr_addr_o,
        input  logic                    instr_gnt_i,
        input  logic                    instr_rvalid_i,
        input  logic                    if_busy_o,
        input  logic                    instr_valid_id_o
);

        // An ungranted request keeps its address
        req_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
                instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
                else $error("instr_addr_o or instr_req_o changed before the grant");

        reset_idle: assert property (@(posedge clk)
                $rose(rst_n_i) |-> !instr_valid_id_o && !instr_req_o)
                else $error("fetch outputs active in the first cycle after reset");

        // busy_o mirrors the outstanding flag
        rvalid_paired: assert property (@(posedge clk) disable iff (!rst_n_i)
                instr_rvalid_i |-> if_busy_o)
                else $error("instr_rvalid_i arrived with no request outstanding");

endmodule

bind if_stage if_stage_assert u_if_stage_assert (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .instr_req_o      (instr_req_o),
        .instr_addr_o     (instr_addr_o),
        .instr_gnt_i      (instr_gnt_i),
        .instr_rvalid_i   (instr_rvalid_i),
        .if_busy_o        (if_busy_o),
        .instr_valid_id_o (instr_valid_id_o)
);

// File: tb/if_stage_stimulus.txt
# kind: 0 boot, 1 jump, 2 trap, 3 mret; op: address, or trap base bits [31:8] for a trap
# columns: kind op(hex) vectored cause(hex) count(decimal) first_pc(hex) stall
0 00000080 0 00 20 00000080 0
1 00001237 0 00 10 00001234 0
2 00000123 1 07 8 0001231C 0
2 00000123 0 07 8 00012300 0
3 20000402 0 00 8 20000400 0
0 00000100 0 00 12 00000100 1
1 FFFFFFF0 0 00 6 FFFFFFF0 0
2 00F00000 1 1F 5 F000007C 0
3 8000000B 0 00 6 80000008 1
1 00000400 0 00 10 00000400 0

// File: tb/tb_if_stage.sv
/*
 * Testbench for the instruction fetch stage
 * Clock, reset, memory model, stimulus file reader and output checks
 */

`timescale 1ns/100ps

module tb_if_stage;
        import fetch_pkg::*;

        localparam logic [31:0] RDATA_KEY    = 32'hA5A50000;
        localparam int          WAIT_LIMIT   = 200;
        localparam int          STALL_CYCLES = 60;

        logic           clk;
        logic           rst_n_i;
        logic           req_i;
        logic           pc_set_i;
        pc_mux_e        pc_mux_i;
        addr_t          boot_addr_i;
        addr_t          jump_target_i;
        addr_t          mepc_i;
        tvec_base_t     trap_base_i;
        logic           trap_vectored_i;
        exc_cause_t     exc_cause_i;
        logic           instr_req_o;
        addr_t          instr_addr_o;
        logic           instr_gnt_i;
        logic           instr_rvalid_i;
        instr_t         instr_rdata_i;
        logic           instr_err_i;
        logic           if_busy_o;
        logic           id_ready_i;
        logic           halt_if_i;
        logic           clear_instr_valid_i;
        logic           instr_valid_id_o;
        instr_t         instr_rdata_id_o;
        addr_t          pc_id_o;
        logic           is_fetch_failed_o;
        logic           perf_imiss_o;

        int             errors;
        int             checks;
        logic           aborted;
        logic [31:0]    rdy_rng;

        if_stage dut (.*);

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        function automatic logic [31:0] xorshift(input logic [31:0] x);
                logic [31:0] y;
                y = x ^ (x << 13);
                y = y ^ (y >> 17);
                y = y ^ (y << 5);
                return y;
        endfunction

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("ERR %s: got %h, expected %h", name, got, exp);
                end
        endtask

        task automatic report_timeout(input string what);
                errors++;
                aborted = 1'b1;
                $display("Timeout: %s", what);
        endtask

        // ------------------------------------------------------------------------
        // Memory model with random grant and response delays
        // ------------------------------------------------------------------------

        initial begin
                logic [31:0]    mem_rng;
                logic [1:0]     gnt_wait;
                logic [1:0]     rsp_wait;
                addr_t          rsp_addr;
                int             rsp_delay;
                instr_gnt_i    = 1'b0;
                instr_rvalid_i = 1'b0;
                instr_rdata_i  = '0;
                instr_err_i    = 1'b0;
                gnt_wait       = 2'd0;
                rsp_wait       = 2'd0;
                rsp_addr       = '0;
                mem_rng        = 32'd3845;
                forever begin
                        @(posedge clk);
                        if (rst_n_i) begin
                                instr_rvalid_i <= 1'b0;
                                if (rsp_wait == 2'd1) begin
                                        instr_rvalid_i <= 1'b1;
                                        instr_rdata_i  <= rsp_addr ^ RDATA_KEY;
                                        instr_err_i    <= (rsp_addr[31:28] == 4'hF);
                                end
                                if (rsp_wait != 2'd0) begin
                                        rsp_wait <= rsp_wait - 2'd1;
                                end
                                if (instr_req_o && instr_gnt_i) begin
                                        mem_rng   = xorshift(mem_rng);
                                        rsp_delay = 1 + int'(mem_rng[3:0] % 3);
                                        if (rsp_delay == 1) begin
                                                instr_rvalid_i <= 1'b1;
                                                instr_rdata_i  <= instr_addr_o ^ RDATA_KEY;
                                                instr_err_i    <= (instr_addr_o[31:28] == 4'hF);
                                        end else begin
                                                rsp_wait <= 2'(rsp_delay - 1);
                                                rsp_addr <= instr_addr_o;
                                        end
                                        // Grant delay of the next request
                                        gnt_wait    <= mem_rng[9:8];
                                        instr_gnt_i <= (mem_rng[9:8] == 2'd0);
                                end else if (instr_req_o) begin
                                        if (gnt_wait <= 2'd1) begin
                                                instr_gnt_i <= 1'b1;
                                                gnt_wait    <= 2'd0;
                                        end else begin
                                                gnt_wait <= gnt_wait - 2'd1;
                                        end
                                end
                        end
                end
        end

        // ------------------------------------------------------------------------
        // Stimulus tasks
        // ------------------------------------------------------------------------

        task automatic redirect(input int kind, input addr_t op, input int vec, input int cause);
                @(posedge clk);
                pc_set_i        <= 1'b1;
                pc_mux_i        <= pc_mux_e'(kind);
                boot_addr_i     <= op;
                jump_target_i   <= op;
                mepc_i          <= op;
                trap_base_i     <= op[23:0];
                trap_vectored_i <= vec[0];
                exc_cause_i     <= cause[4:0];
                @(posedge clk);
                pc_set_i <= 1'b0;
                // Queue flushed and register empty, so decode sees a miss
                @(posedge clk);
                check_value("perf_imiss_o", 32'(perf_imiss_o), 32'd1);
        endtask

        // With decode held off the output stays put and fetching stops
        task automatic hold_under_stall();
                logic   held;
                addr_t  held_pc;
                instr_t held_rdata;
                held       = 1'b0;
                held_pc    = '0;
                held_rdata = '0;
                id_ready_i <= 1'b0;
                for (int cyc = 0; cyc < STALL_CYCLES; cyc++) begin
                        @(posedge clk);
                        if (instr_valid_id_o && !held) begin
                                held       = 1'b1;
                                held_pc    = pc_id_o;
                                held_rdata = instr_rdata_id_o;
                        end else if (held) begin
                                check_value("instr_valid_id_o", 32'(instr_valid_id_o), 32'd1);
                                check_value("pc_id_o", pc_id_o, held_pc);
                                check_value("instr_rdata_id_o", instr_rdata_id_o, held_rdata);
                        end
                        if (cyc >= STALL_CYCLES - 10) begin
                                check_value("instr_req_o", 32'(instr_req_o), 32'd0);
                        end
                end
                if (!held) begin
                        report_timeout("no instruction reached decode during the stall");
                end
        endtask

        task automatic consume(input int count, input addr_t first_pc);
                addr_t  exp_pc;
                int     taken;
                int     waited;
                exp_pc = first_pc;
                taken  = 0;
                waited = 0;
                while (taken < count && waited < WAIT_LIMIT) begin
                        @(posedge clk);
                        if (instr_valid_id_o && id_ready_i) begin
                                check_value("pc_id_o", pc_id_o, exp_pc);
                                check_value("instr_rdata_id_o", instr_rdata_id_o,
                                            exp_pc ^ RDATA_KEY);
                                check_value("is_fetch_failed_o", 32'(is_fetch_failed_o),
                                            32'(exp_pc[31:28] == 4'hF));
                                exp_pc = exp_pc + 32'd4;
                                taken++;
                                waited = 0;
                        end else begin
                                waited++;
                        end
                        rdy_rng = xorshift(rdy_rng);
                        id_ready_i <= (rdy_rng[1:0] != 2'b00);
                end
                if (taken < count) begin
                        report_timeout("instruction stream to decode stopped");
                end
        endtask

        task automatic clear_check();
                int waited;
                @(posedge clk);
                id_ready_i <= 1'b0;
                @(posedge clk);
                waited = 0;
                while (!instr_valid_id_o && waited < WAIT_LIMIT) begin
                        @(posedge clk);
                        waited++;
                end
                if (!instr_valid_id_o) begin
                        report_timeout("no valid instruction to clear");
                end else begin
                        clear_instr_valid_i <= 1'b1;
                        @(posedge clk);
                        clear_instr_valid_i <= 1'b0;
                        @(posedge clk);
                        check_value("instr_valid_id_o", 32'(instr_valid_id_o), 32'd0);
                end
        endtask

        task automatic run_redirect_case(input int kind, input addr_t op, input int vec,
                                         input int cause, input int count,
                                         input addr_t first_pc, input int stall);
                redirect(kind, op, vec, cause);
                if (stall != 0) begin
                        hold_under_stall();
                end
                if (!aborted) begin
                        consume(count, first_pc);
                end
                if (!aborted) begin
                        clear_check();
                end
        endtask

        // ------------------------------------------------------------------------
        // Main sequence
        // ------------------------------------------------------------------------

        initial begin
                int     fd;
                int     got;
                int     fields;
                string  line;
                int     kind;
                addr_t  op;
                int     vec;
                int     cause;
                int     count;
                addr_t  first_pc;
                int     stall;
                rst_n_i             = 1'b0;
                req_i               = 1'b0;
                pc_set_i            = 1'b0;
                pc_mux_i            = PC_BOOT;
                boot_addr_i         = '0;
                jump_target_i       = '0;
                mepc_i              = '0;
                trap_base_i         = '0;
                trap_vectored_i     = 1'b0;
                exc_cause_i         = '0;
                id_ready_i          = 1'b0;
                halt_if_i           = 1'b0;
                clear_instr_valid_i = 1'b0;
                errors              = 0;
                checks              = 0;
                aborted             = 1'b0;
                rdy_rng             = xorshift(32'd3845);

                repeat (2) @(posedge clk);
                rst_n_i <= 1'b1;
                req_i   <= 1'b1;

                // No fetch has been started yet
                @(posedge clk);
                check_value("perf_imiss_o", 32'(perf_imiss_o), 32'd0);
                check_value("if_busy_o", 32'(if_busy_o), 32'd0);

                fd = $fopen("tb/if_stage_stimulus.txt", "r");
                if (fd == 0) begin
                        errors++;
                        $display("Could not open the stimulus file");
                end else begin
                        while (!$feof(fd) && !aborted) begin
                                line = "";
                                got  = $fgets(line, fd);
                                // Comment and blank lines carry no redirect
                                if (got > 0 && line.getc(0) != "#") begin
                                        fields = $sscanf(line, "%h %h %h %h %d %h %h", kind, op,
                                                         vec, cause, count, first_pc, stall);
                                        if (fields == 7) begin
                                                run_redirect_case(kind, op, vec, cause, count,
                                                                  first_pc, stall);
                                        end
                                end
                        end
                        $fclose(fd);
                end

                $display("Checks %0d, errors %0d", checks, errors);
                if (errors == 0) begin
                        $display("NO ERRORS");
                end else begin
                        $display("ERRORS FOUND");
                end
                $finish;
        end

endmodule
